// ==== project.f ====
opc_pkg.sv
opc_mem_if.sv
opc_cpu.sv
opc_host_port.sv
opc_ram.sv
opc_system.sv
tb_opc_system.sv

// ==== Bender.yml ====
package:
  name: opc_system

sources:
  - opc_pkg.sv
  - opc_mem_if.sv
  - opc_cpu.sv
  - opc_host_port.sv
  - opc_ram.sv
  - opc_system.sv
  - target: simulation
    files:
      - tb_opc_system.sv

// ==== tb_opc_system.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_opc_system;
  import opc_pkg::*;

  localparam int ack_timeout = 64;

  logic              clk;
  logic              reset_b;
  logic              run;
  logic              host_req;
  logic              host_write;
  logic [addr_w-1:0] host_addr;
  logic [data_w-1:0] host_wdata;
  logic              host_ack;
  logic [data_w-1:0] host_rdata;

  logic [data_w-1:0] shadow [1 << addr_w]; // Expected memory image.
  logic [addr_w-1:0] at;                   // Next code address while loading.
  logic [addr_w-1:0] addrs [$];
  int                seed = 32'hcb2f;
  int                data_errors = 0;
  int                handshake_errors = 0;
  int                timeouts = 0;

  opc_system uut (
    .clk        (clk),
    .reset_b    (reset_b),
    .run        (run),
    .host_req   (host_req),
    .host_write (host_write),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .host_ack   (host_ack),
    .host_rdata (host_rdata)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ack_needs_req: assert property (@(posedge clk) disable iff (!reset_b)
    host_ack |-> (host_req || $past(host_req)))
    else
    begin
      handshake_errors++;
      $display("Handshake error at %0t ns: host_ack is high without host_req", $time);
    end

  ack_falls_late: assert property (@(posedge clk) disable iff (!reset_b)
    $fell(host_ack) |-> !host_req)
    else
    begin
      handshake_errors++;
      $display("Handshake error at %0t ns: host_ack fell while host_req was high", $time);
    end

  rdata_held: assert property (@(posedge clk) disable iff (!reset_b)
    (host_ack && $past(host_ack)) |-> $stable(host_rdata))
    else
    begin
      handshake_errors++;
      $display("Handshake error at %0t ns: host_rdata changed while host_ack was high", $time);
    end

  task automatic apply_reset();
    begin
      @(posedge clk);
      reset_b <= 1'b0;
      repeat (3) @(posedge clk);
      reset_b <= 1'b1;
    end
  endtask

  // Waits at falling edges for host_ack to reach the given level.
  task automatic wait_ack(input logic level);
    int n;
    begin
      n = 0;
      @(negedge clk);
      while (host_ack !== level && n < ack_timeout)
      begin
        @(negedge clk);
        n++;
      end
      if (host_ack !== level)
      begin
        timeouts++;
        $display("Timeout at %0t ns: host_ack did not go to %b", $time, level);
      end
    end
  endtask

  task automatic write_mem(input logic [addr_w-1:0] a, input logic [data_w-1:0] d);
    begin
      @(posedge clk);
      host_addr  <= a;
      host_wdata <= d;
      host_write <= 1'b1;
      host_req   <= 1'b1;
      wait_ack(1'b1);
      @(posedge clk);
      host_req <= 1'b0;
      wait_ack(1'b0);
      shadow[a] = d;
    end
  endtask

  task automatic read_mem(input logic [addr_w-1:0] a, output logic [data_w-1:0] d);
    begin
      @(posedge clk);
      host_addr  <= a;
      host_write <= 1'b0;
      host_req   <= 1'b1;
      wait_ack(1'b1);
      d = host_rdata;
      @(posedge clk);
      host_req <= 1'b0;
      wait_ack(1'b0);
    end
  endtask

  task automatic check_byte(input logic [addr_w-1:0] a);
    logic [data_w-1:0] got;
    begin
      read_mem(a, got);
      assert (got === shadow[a])
      else
      begin
        data_errors++;
        $display("Error at %0t ns: host_rdata at address %h is %h, expected %h",
                 $time, a, got, shadow[a]);
      end
    end
  endtask

  task automatic check_range(input logic [addr_w-1:0] first, input int count);
    begin
      for (int i = 0; i < count; i++)
      begin
        check_byte(first + addr_w'(i));
      end
    end
  endtask

  // Writes one two-byte instruction at the load address.
  task automatic emit(input logic direct, input logic [op_w-1:0] op,
                      input logic [addr_w-1:0] a);
    begin
      write_mem(at, {direct, op, a[11:8]});
      write_mem(at + 12'd1, a[7:0]);
      at = at + 12'd2;
    end
  endtask

  task automatic emit_halt();
    begin
      emit(1'b0, op_jp, at);
    end
  endtask

  // Instruction-set model run on the shadow image from the reset state.
  task automatic run_model(output int cycles);
    logic [addr_w-1:0] pc;
    logic [addr_w-1:0] ia;
    logic [addr_w-1:0] tgt;
    logic [data_w-1:0] acc;
    logic [data_w-1:0] b0;
    logic [data_w-1:0] b1;
    logic [data_w-1:0] opnd;
    logic [data_w:0]   s;
    logic              c;
    logic              from_mem;
    logic              done;
    int                steps;
    begin
      pc = '0;
      acc = '0;
      c = 1'b0;
      done = 1'b0;
      steps = 0;
      cycles = 0;
      while (!done && steps < 2000)
      begin
        ia = pc;
        b0 = shadow[pc];
        b1 = shadow[pc + 12'd1];
        pc = pc + 12'd2;
        tgt = {b0[3:0], b1};
        from_mem = b0[7] && (b0[6:4] inside {op_and, op_lda, op_add, op_not});
        opnd = from_mem ? shadow[tgt] : b1;
        cycles += from_mem ? 4 : 3;
        case (b0[6:4])
          op_and:
          begin
            acc = acc & opnd;
            c = 1'b0;
          end
          op_lda: acc = opnd;
          op_sta: shadow[tgt] = acc;
          op_add:
          begin
            s = {1'b0, acc} + {1'b0, opnd} + {8'h00, c};
            {c, acc} = s;
          end
          op_not: acc = ~opnd;
          op_jpc: if (c) pc = tgt;
          op_jpz: if (acc == 8'h00) pc = tgt;
          default: pc = tgt;
        endcase
        done = (pc == ia); // Jump to itself ends the program.
        steps++;
      end
      if (!done)
      begin
        data_errors++;
        $display("Model did not reach the final jump of the program");
      end
    end
  endtask

  task automatic run_program(input bit with_reads);
    int                cycles;
    int                gap;
    begin
      run_model(cycles);
      @(posedge clk);
      run <= 1'b1;
      if (with_reads)
      begin
        repeat (4)
        begin
          gap = ($random(seed) & 31) + 5;
          repeat (gap) @(posedge clk);
          check_byte(12'h001); // Core stalls at a boundary, then resumes.
        end
      end
      repeat (2 * cycles + 40) @(posedge clk);
      run <= 1'b0;
    end
  endtask

  task automatic load_logic_prog();
    begin
      write_mem(12'h200, 8'($random(seed)));
      write_mem(12'h201, 8'($random(seed)));
      at = '0;
      emit(1'b0, op_lda, {4'h7, 8'($random(seed))}); // Upper nibble is ignored.
      emit(1'b0, op_sta, 12'h300);
      emit(1'b0, op_and, {4'h0, 8'($random(seed))});
      emit(1'b0, op_sta, 12'h301);
      emit(1'b1, op_lda, 12'h200);
      emit(1'b1, op_and, 12'h201);
      emit(1'b0, op_sta, 12'h302);
      emit(1'b0, op_not, {4'h0, 8'($random(seed))});
      emit(1'b0, op_sta, 12'h303);
      emit(1'b1, op_not, 12'h201);
      emit(1'b0, op_sta, 12'h304);
      emit(1'b1, op_lda, 12'h201);
      emit(1'b1, op_sta, 12'h305);
      emit_halt();
    end
  endtask

  task automatic load_add_prog();
    begin
      for (int i = 0; i < 3; i++)
      begin
        write_mem(12'h400 + 12'(i), 8'($random(seed)));
        write_mem(12'h410 + 12'(i), 8'($random(seed)));
      end
      at = '0;
      emit(1'b1, op_lda, 12'h400);
      emit(1'b0, op_and, 12'h0ff);
      emit(1'b1, op_add, 12'h410);
      emit(1'b0, op_sta, 12'h420);
      emit(1'b1, op_lda, 12'h401);
      emit(1'b1, op_add, 12'h411);
      emit(1'b0, op_sta, 12'h421);
      emit(1'b1, op_lda, 12'h402);
      emit(1'b1, op_add, 12'h412);
      emit(1'b0, op_sta, 12'h422);
      emit(1'b0, op_lda, 12'h000);
      emit(1'b0, op_add, 12'h000);
      emit(1'b0, op_sta, 12'h423); // Final carry.
      emit(1'b0, op_lda, 12'h0ff);
      emit(1'b0, op_add, 12'h001);
      emit(1'b0, op_and, 12'h0ff); // Carry must be gone after this.
      emit(1'b0, op_add, 12'h000);
      emit(1'b0, op_sta, 12'h424);
      emit_halt();
    end
  endtask

  task automatic load_loop_prog(input logic [data_w-1:0] n);
    logic [addr_w-1:0] top;
    begin
      at = '0;
      emit(1'b0, op_lda, {4'h0, n});
      emit(1'b0, op_sta, 12'h500);
      emit(1'b0, op_lda, 12'h000);
      emit(1'b0, op_sta, 12'h501);
      top = at;
      emit(1'b1, op_lda, 12'h500);
      emit(1'b0, op_jpz, 12'h040);
      emit(1'b0, op_and, 12'h0ff);
      emit(1'b0, op_add, 12'h0ff); // Decrement.
      emit(1'b0, op_sta, 12'h500);
      emit(1'b1, op_lda, 12'h501);
      emit(1'b0, op_and, 12'h0ff);
      emit(1'b0, op_add, 12'h001);
      emit(1'b0, op_sta, 12'h501);
      emit(1'b0, op_jp, top);
      at = 12'h040;
      emit(1'b0, op_and, 12'h0ff);
      emit(1'b0, op_jpc, 12'h080);
      emit(1'b0, op_lda, 12'h011);
      emit(1'b0, op_sta, 12'h502);
      emit(1'b0, op_lda, 12'h0f0);
      emit(1'b0, op_add, 12'h020);
      emit(1'b0, op_jpc, 12'h060);
      emit(1'b0, op_lda, 12'h0ee);
      emit(1'b0, op_sta, 12'h503);
      emit_halt();
      at = 12'h060;
      emit(1'b0, op_lda, 12'h05a);
      emit(1'b0, op_sta, 12'h503);
      emit_halt();
      at = 12'h080;
      emit(1'b0, op_lda, 12'h0bb);
      emit(1'b0, op_sta, 12'h502);
      emit_halt();
    end
  endtask

  initial
  begin
    logic [addr_w-1:0] a;
    reset_b    = 1'b0;
    run        = 1'b0;
    host_req   = 1'b0;
    host_write = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    at         = '0;
    apply_reset();

    @(negedge clk);
    assert (host_ack === 1'b0)
    else
    begin
      data_errors++;
      $display("Error at %0t ns: host_ack is %b, expected 0", $time, host_ack);
    end
    for (int i = 0; i < 24; i++)
    begin
      a = addr_w'($random(seed));
      write_mem(a, 8'($random(seed)));
      addrs.push_back(a);
    end
    foreach (addrs[i])
    begin
      check_byte(addrs[i]);
    end

    apply_reset();
    load_logic_prog();
    run_program(1'b0);
    check_range(12'h300, 6);

    repeat (3)
    begin
      apply_reset();
      load_add_prog();
      run_program(1'b0);
      check_range(12'h420, 5);
    end

    apply_reset();
    load_loop_prog(8'(($random(seed) & 15) + 1));
    run_program(1'b0);
    check_range(12'h500, 4);

    // Same loop with host reads while the core runs.
    apply_reset();
    load_loop_prog(8'(($random(seed) & 15) + 1));
    run_program(1'b1);
    check_range(12'h500, 4);

    repeat (2) @(posedge clk);
    $display("Summary: %0d data errors, %0d handshake errors, %0d timeouts",
             data_errors, handshake_errors, timeouts);
    if (data_errors == 0 && handshake_errors == 0 && timeouts == 0)
    begin
      $display("** PASS **");
    end
    else
    begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== opc_system.sv ====
`timescale 1ns/10ps
`default_nettype none

module opc_system (
  input  logic                        clk,
  input  logic                        reset_b,
  input  logic                        run,
  input  logic                        host_req,
  input  logic                        host_write,
  input  logic [opc_pkg::addr_w-1:0]  host_addr,
  input  logic [opc_pkg::data_w-1:0]  host_wdata,
  output logic                        host_ack,
  output logic [opc_pkg::data_w-1:0]  host_rdata
);

  logic hold;
  logic boundary;

  opc_mem_if cpu_bus ();  // Core side of the host port.
  opc_mem_if ram_bus ();  // RAM side of the host port.

  opc_cpu u_cpu (
    .clk      (clk),
    .reset_b  (reset_b),
    .hold     (hold),
    .boundary (boundary),
    .bus      (cpu_bus.master)
  );

  opc_host_port u_host_port (
    .clk        (clk),
    .reset_b    (reset_b),
    .run        (run),
    .host_req   (host_req),
    .host_write (host_write),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .host_ack   (host_ack),
    .host_rdata (host_rdata),
    .hold       (hold),
    .boundary   (boundary),
    .cpu        (cpu_bus.mem),
    .mem        (ram_bus.master)
  );

  opc_ram u_ram (
    .clk (clk),
    .bus (ram_bus.mem)
  );

endmodule

`default_nettype wire

// ==== opc_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

module opc_ram (
  input  logic   clk,
  opc_mem_if.mem bus
);
  import opc_pkg::*;

  localparam int depth = 1 << addr_w;

  logic [data_w-1:0] mem_q [depth];

  always_ff @(posedge clk)
  begin
    if (bus.we)
    begin
      mem_q[bus.addr] <= bus.wdata;
    end
  end

  // Asynchronous read, zero when nobody samples.
  assign bus.rdata = bus.rd ? mem_q[bus.addr] : '0;

endmodule

`default_nettype wire

// ==== opc_host_port.sv ====
`timescale 1ns/10ps
`default_nettype none

module opc_host_port (
  input  logic                        clk,
  input  logic                        reset_b,
  input  logic                        run,
  input  logic                        host_req,
  input  logic                        host_write,
  input  logic [opc_pkg::addr_w-1:0]  host_addr,
  input  logic [opc_pkg::data_w-1:0]  host_wdata,
  output logic                        host_ack,
  output logic [opc_pkg::data_w-1:0]  host_rdata,
  output logic                        hold,
  input  logic                        boundary,
  opc_mem_if.mem                      cpu,
  opc_mem_if.master                   mem
);

  typedef enum logic [1:0] {
    hs_idle   = 2'b00,
    hs_wait   = 2'b01,
    hs_access = 2'b10,
    hs_ack    = 2'b11
  } hs_state_t;

  hs_state_t hs_q;
  logic      host_sel;

  always_ff @(posedge clk or negedge reset_b)
  begin
    if (!reset_b)
    begin
      hs_q <= hs_idle;
    end
    else
    begin
      case (hs_q)
        hs_idle:
        begin
          if (host_req)
          begin
            hs_q <= hs_wait;
          end
        end
        hs_wait:
        begin
          if (boundary)
          begin
            hs_q <= hs_access; // Core is parked in fetch0.
          end
        end
        hs_access:
        begin
          hs_q <= hs_ack;
        end
        default:
        begin
          if (!host_req)
          begin
            hs_q <= hs_idle;
          end
        end
      endcase
    end
  end

  assign host_ack = (hs_q == hs_ack);
  assign host_sel = (hs_q == hs_access);

  // Stall from the request until the handshake closes.
  assign hold = !run || host_req || (hs_q != hs_idle);

  assign mem.addr  = host_sel ? host_addr  : cpu.addr;
  assign mem.wdata = host_sel ? host_wdata : cpu.wdata;
  assign mem.we    = host_sel ? host_write : cpu.we;
  assign mem.rd    = host_sel ? !host_write : cpu.rd;
  assign cpu.rdata = mem.rdata;

  always_ff @(posedge clk or negedge reset_b)
  begin
    if (!reset_b)
    begin
      host_rdata <= '0;
    end
    else if (host_sel && !host_write)
    begin
      host_rdata <= mem.rdata; // Held until the next read.
    end
  end

endmodule

`default_nettype wire

// ==== opc_cpu.sv ====
`timescale 1ns/10ps
`default_nettype none

module opc_cpu (
  input  logic     clk,
  input  logic     reset_b,
  input  logic     hold,
  output logic     boundary,
  opc_mem_if.master bus
);
  import opc_pkg::*;

  opc_state_t        state_q;
  logic [ir_w-1:0]   ir_q;
  logic [addr_w-1:0] or_q;
  logic [addr_w-1:0] pc_q;
  logic [data_w-1:0] acc_q;
  logic              c_q;

  logic [op_w-1:0]   op;
  logic              has_operand;
  logic              direct;
  logic              run_fetch;
  logic              writeback;
  logic [data_w:0]   sum;

  assign op          = ir_q[op_w-1:0];
  assign has_operand = (op == op_and) || (op == op_lda) ||
                       (op == op_add) || (op == op_not);
  assign direct      = ir_q[mode_bit] && has_operand; // STA and jumps never read memory.

  assign run_fetch = (state_q == fetch0) && !hold;
  assign writeback = (state_q == exec) && (op == op_sta);
  assign boundary  = (state_q == fetch0) && hold;

  assign bus.addr  = (writeback || state_q == rdmem) ? or_q : pc_q;
  assign bus.wdata = acc_q;
  assign bus.we    = writeback;
  assign bus.rd    = run_fetch || (state_q == fetch1) || (state_q == rdmem);

  assign sum = {1'b0, acc_q} + {1'b0, or_q[data_w-1:0]} + {{data_w{1'b0}}, c_q};

  always_ff @(posedge clk or negedge reset_b)
  begin
    if (!reset_b)
    begin
      state_q <= fetch0;
    end
    else
    begin
      case (state_q)
        fetch0:
        begin
          if (!hold)
          begin
            state_q <= fetch1;
          end
        end
        fetch1:  state_q <= direct ? rdmem : exec;
        rdmem:   state_q <= exec;
        default: state_q <= fetch0;
      endcase
    end
  end

  // Instruction and operand registers.
  always_ff @(posedge clk)
  begin
    if (run_fetch)
    begin
      ir_q               <= bus.rdata[data_w-1:opc_lsb];
      or_q[addr_w-1:data_w] <= bus.rdata[ahi_msb:0];
    end
    if (state_q == fetch1 || state_q == rdmem)
    begin
      or_q[data_w-1:0] <= bus.rdata; // Memory operand replaces the low byte.
    end
  end

  always_ff @(posedge clk or negedge reset_b)
  begin
    if (!reset_b)
    begin
      acc_q <= '0;
      c_q   <= 1'b0;
    end
    else if (state_q == exec)
    begin
      case (op)
        op_and:
        begin
          acc_q <= acc_q & or_q[data_w-1:0];
          c_q   <= 1'b0;
        end
        op_lda:  acc_q <= or_q[data_w-1:0];
        op_not:  acc_q <= ~or_q[data_w-1:0];
        op_add:  {c_q, acc_q} <= sum;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk or negedge reset_b)
  begin
    if (!reset_b)
    begin
      pc_q <= '0;
    end
    else if (run_fetch || state_q == fetch1)
    begin
      pc_q <= pc_q + 1'b1;
    end
    else if (state_q == exec)
    begin
      case (op)
        op_jp:
        begin
          pc_q <= or_q;
        end
        op_jpc:
        begin
          if (c_q)
          begin
            pc_q <= or_q;
          end
        end
        op_jpz:
        begin
          if (acc_q == '0)
          begin
            pc_q <= or_q;
          end
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== opc_mem_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface opc_mem_if;
  import opc_pkg::*;

  logic [addr_w-1:0] addr;
  logic [data_w-1:0] wdata;
  logic [data_w-1:0] rdata;
  logic              we;    // Write strobe.
  logic              rd;    // Master samples rdata this cycle.

  modport master (
    output addr,
    output wdata,
    output we,
    output rd,
    input  rdata
  );

  modport mem (
    input  addr,
    input  wdata,
    input  we,
    input  rd,
    output rdata
  );

endinterface

`default_nettype wire

// ==== opc_pkg.sv ====
`default_nettype none

package opc_pkg;

  // Bus widths.
  localparam int addr_w = 12;
  localparam int data_w = 8;

  // Instruction register holds the opcode nibble.
  localparam int ir_w = 4;
  localparam int op_w = 3;

  // Direct-mode bit inside the opcode nibble.
  localparam int mode_bit = 3;

  // Byte 0 field positions.
  localparam int opc_lsb = 4;
  localparam int ahi_msb = addr_w - data_w - 1;

  typedef enum logic [1:0] {
    fetch0 = 2'b00,
    fetch1 = 2'b01,
    rdmem  = 2'b10,
    exec   = 2'b11
  } opc_state_t;

  localparam logic [op_w-1:0] op_and = 3'd0;
  localparam logic [op_w-1:0] op_lda = 3'd1;
  localparam logic [op_w-1:0] op_sta = 3'd2;
  localparam logic [op_w-1:0] op_add = 3'd3;
  localparam logic [op_w-1:0] op_not = 3'd4;
  localparam logic [op_w-1:0] op_jpc = 3'd5;
  localparam logic [op_w-1:0] op_jpz = 3'd6;
  localparam logic [op_w-1:0] op_jp  = 3'd7;

endpackage

`default_nettype wire
